//--- noc_pkg.sv
/*
 * Shared types for the 5-port mesh router.
 * Coordinates are 2 bits wide, so a mesh can be at most 4 by 4.
 * Every flit is a single word and carries its own destination.
 */
package noc_pkg;

    // Widths of the flit fields
    localparam int COORD_WIDTH   = 2;
    localparam int PAYLOAD_WIDTH = 28;

    // Router port count and port index width
    localparam int NUM_PORTS = 5;
    localparam int PORT_BITS = 3;

    typedef logic [COORD_WIDTH-1:0] coord_t;

    // One 32-bit flit, with the destination in the upper bits
    typedef struct packed {
        coord_t                   dst_x;
        coord_t                   dst_y;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } flit_t;

    // Port numbering, shared by the route computation and the testbench
    typedef enum logic [PORT_BITS-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_EAST  = 3'd3,
        PORT_WEST  = 3'd4
    } port_e;

    // One bit per port, for requests, grants and valids
    typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

//--- flit_fifo.sv
/*
 * Circular flit buffer. BUFFER_DEPTH must be a power of two and at least 2.
 * A push while full or a pop while empty is ignored.
 * rd_flit shows the head entry combinationally.
 */
module flit_fifo #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           push,
    input  logic           pop,
    input  noc_pkg::flit_t wr_flit,
    output noc_pkg::flit_t rd_flit,
    output logic           empty,
    output logic           full
);

    localparam int ADDR_BITS = $clog2(BUFFER_DEPTH);

    noc_pkg::flit_t mem [BUFFER_DEPTH];

    // Pointers carry one extra wrap bit
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Same index with different wrap bits means the buffer is full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                   (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    assign rd_flit = mem[rd_ptr[ADDR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= wr_flit;
        end
    end

endmodule

//--- input_port.sv
/*
 * One router input: flit buffer, XY route computation on the head flit
 * and the upstream credit return. Credit flow upstream must keep the
 * buffer from overflowing, since a flit that arrives while it is full is dropped.
 */
module input_port #(
    parameter int BUFFER_DEPTH = 4,
    parameter int ROUTER_X     = 1,
    parameter int ROUTER_Y     = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  noc_pkg::flit_t     in_flit,
    input  logic               in_valid,
    input  logic               pop,
    output noc_pkg::flit_t     head_flit,
    output logic               head_valid,
    output noc_pkg::port_vec_t route_req,
    output logic               credit_out
);

    localparam noc_pkg::coord_t MY_X = noc_pkg::coord_t'(ROUTER_X);
    localparam noc_pkg::coord_t MY_Y = noc_pkg::coord_t'(ROUTER_Y);

    logic fifo_empty;
    logic fifo_full;
    logic fifo_push;

    assign fifo_push = in_valid && !fifo_full;

    flit_fifo #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .reset   (reset),
        .push    (fifo_push),
        .pop     (pop),
        .wr_flit (in_flit),
        .rd_flit (head_flit),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    assign head_valid = !fifo_empty;

    // Dimension-ordered routing, X first and then Y
    always_comb begin
        route_req = '0;
        if (head_flit.dst_x > MY_X) begin
            route_req[noc_pkg::PORT_EAST] = 1'b1;
        end else if (head_flit.dst_x < MY_X) begin
            route_req[noc_pkg::PORT_WEST] = 1'b1;
        end else if (head_flit.dst_y > MY_Y) begin
            route_req[noc_pkg::PORT_NORTH] = 1'b1;
        end else if (head_flit.dst_y < MY_Y) begin
            route_req[noc_pkg::PORT_SOUTH] = 1'b1;
        end else begin
            route_req[noc_pkg::PORT_LOCAL] = 1'b1;
        end
    end

    // One credit goes back upstream per flit that leaves the buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= pop;
        end
    end

endmodule

//--- switch_allocator.sv
/*
 * Separate round-robin arbiter for each output, gated by that output's credit count.
 * Counters start at BUFFER_DEPTH and assume that downstream never returns
 * more credits than it was given. Each input requests a single output at a time.
 */
module switch_allocator #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  noc_pkg::port_vec_t route_req [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_vec_t head_valid,
    input  noc_pkg::port_vec_t credit_in,
    output noc_pkg::port_vec_t grant [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t grant_valid,
    output noc_pkg::port_vec_t pop
);

    localparam int NUM_PORTS = noc_pkg::NUM_PORTS;
    localparam int PORT_BITS = noc_pkg::PORT_BITS;
    localparam int CR_BITS   = $clog2(BUFFER_DEPTH) + 1;

    // Requests seen by each output, one bit per input
    noc_pkg::port_vec_t   out_req [NUM_PORTS];

    // Search start for each output, the input just after its last winner
    logic [PORT_BITS-1:0] rr_ptr  [NUM_PORTS];

    // Free slots in the downstream buffer of each output
    logic [CR_BITS-1:0]   credits [NUM_PORTS];

    // First requester at or after start, returned as a one-hot vector
    function automatic noc_pkg::port_vec_t rr_pick(
        input noc_pkg::port_vec_t   req,
        input logic [PORT_BITS-1:0] start
    );
        noc_pkg::port_vec_t pick;
        int                 idx;
        logic               found;
        pick  = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(start) + k) % NUM_PORTS;
            if (!found && req[idx]) begin
                pick[idx] = 1'b1;
                found     = 1'b1;
            end
        end
        return pick;
    endfunction

    always_comb begin
        pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                out_req[o][i] = head_valid[i] & route_req[i][o];
            end
            grant_valid[o] = (|out_req[o]) && (credits[o] != '0);
            grant[o]       = grant_valid[o] ? rr_pick(out_req[o], rr_ptr[o]) : '0;
            // Each grant vector is indexed by input, so OR them into pop
            pop = pop | grant[o];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                credits[o] <= CR_BITS'(BUFFER_DEPTH);
                rr_ptr[o]  <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                // Spend on a grant and regain on a returned credit, both may coincide
                credits[o] <= credits[o] - CR_BITS'(grant_valid[o]) + CR_BITS'(credit_in[o]);
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (grant[o][i]) begin
                        rr_ptr[o] <= PORT_BITS'((i + 1) % NUM_PORTS);
                    end
                end
            end
        end
    end

endmodule

//--- crossbar.sv
/*
 * Registered 5x5 crossbar. Grants must be one-hot or zero per output.
 * out_flit holds its last value while out_valid is low.
 */
module crossbar (
    input  logic               clk,
    input  logic               reset,
    input  noc_pkg::flit_t     head_flit [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_vec_t grant [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_vec_t grant_valid,
    output noc_pkg::flit_t     out_flit [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t out_valid
);

    localparam int NUM_PORTS = noc_pkg::NUM_PORTS;

    noc_pkg::flit_t xbar_sel [NUM_PORTS];

    // One-hot select of the granted input for each output
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            xbar_sel[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant[o][i]) begin
                    xbar_sel[o] = head_flit[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
        end else begin
            out_valid <= grant_valid;
        end
    end

    // Flit registers load only on a grant
    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (grant_valid[o]) begin
                out_flit[o] <= xbar_sel[o];
            end
        end
    end

endmodule

//--- router_top.sv
/*
 * Five-port input-buffered mesh router with XY routing and credit flow on every port.
 * A sender must hold a credit before it raises in_valid and starts with BUFFER_DEPTH.
 * Uncontested latency from in_valid to out_valid is two cycles.
 */
module router_top #(
    parameter int BUFFER_DEPTH = 4,
    parameter int ROUTER_X     = 1,
    parameter int ROUTER_Y     = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  noc_pkg::flit_t     in_flit [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_vec_t in_valid,
    input  noc_pkg::port_vec_t credit_in,
    output noc_pkg::flit_t     out_flit [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t out_valid,
    output noc_pkg::port_vec_t credit_out
);

    localparam int NUM_PORTS = noc_pkg::NUM_PORTS;

    // Input side to allocator and crossbar
    noc_pkg::flit_t     head_flit [NUM_PORTS];
    noc_pkg::port_vec_t route_req [NUM_PORTS];
    noc_pkg::port_vec_t head_valid;

    // Allocator results
    noc_pkg::port_vec_t grant [NUM_PORTS];
    noc_pkg::port_vec_t grant_valid;
    noc_pkg::port_vec_t pop;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        input_port #(
            .BUFFER_DEPTH (BUFFER_DEPTH),
            .ROUTER_X     (ROUTER_X),
            .ROUTER_Y     (ROUTER_Y)
        ) u_input_port (
            .clk        (clk),
            .reset      (reset),
            .in_flit    (in_flit[i]),
            .in_valid   (in_valid[i]),
            .pop        (pop[i]),
            .head_flit  (head_flit[i]),
            .head_valid (head_valid[i]),
            .route_req  (route_req[i]),
            .credit_out (credit_out[i])
        );
    end

    switch_allocator #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_switch_allocator (
        .clk         (clk),
        .reset       (reset),
        .route_req   (route_req),
        .head_valid  (head_valid),
        .credit_in   (credit_in),
        .grant       (grant),
        .grant_valid (grant_valid),
        .pop         (pop)
    );

    crossbar u_crossbar (
        .clk         (clk),
        .reset       (reset),
        .head_flit   (head_flit),
        .grant       (grant),
        .grant_valid (grant_valid),
        .out_flit    (out_flit),
        .out_valid   (out_valid)
    );

endmodule

//--- router_asserts.sv
/*
 * Concurrent checks on the switch allocator, bound into every instance.
 * Rules are not checked while reset is high.
 */
module router_asserts #(
    parameter int BUFFER_DEPTH = 4
) (
    input logic                                 clk,
    input logic                                 reset,
    input noc_pkg::port_vec_t                   grant [noc_pkg::NUM_PORTS],
    input logic [$clog2(BUFFER_DEPTH):0]        credits [noc_pkg::NUM_PORTS]
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS = noc_pkg::NUM_PORTS;

    // Outputs won by each input in the current cycle
    noc_pkg::port_vec_t won [NUM_PORTS];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++)
            for (int o = 0; o < NUM_PORTS; o++)
                won[i][o] = grant[o][i];
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        // A grant with no credit left wraps the counter past BUFFER_DEPTH
        a_credit: assert property (@(posedge clk) disable iff (reset)
            credits[o] <= BUFFER_DEPTH)
            else $error("Output %0d credit count out of range", o);
        a_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(grant[o]))
            else $error("Output %0d grant is not one-hot", o);
        a_single: assert property (@(posedge clk) disable iff (reset)
            $onehot0(won[o]))
            else $error("Input %0d granted more than one output", o);
    end

endmodule

bind switch_allocator router_asserts #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
) u_asserts (
    .clk         (clk),
    .reset       (reset),
    .grant       (grant),
    .credits     (credits)
);

//--- tb_router.sv
/*
 * Testbench for router_top at (1,1) with 4-deep buffers.
 * Inputs are driven and outputs sampled on the falling clock edge.
 * The top three payload bits carry the source port, so every flit is traced per source.
 */
module tb_router;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUFFER_DEPTH = 4;
    localparam int NUM_PORTS    = noc_pkg::NUM_PORTS;
    localparam int NUM_ENTRIES  = 17;
    localparam int NUM_TESTS    = 5;

    typedef struct packed {
        int test;
        int src;
        int dx;
        int dy;
        int exp_port;
        int count;
        bit hold;
    } entry_t;

    typedef struct packed {
        noc_pkg::flit_t flit;
        int             port;
    } pend_t;

    typedef struct packed {
        noc_pkg::flit_t flit;
        int             send_cycle;
    } sb_t;

    // Test, source, destination x and y, expected output, flit count, hold downstream credits
    entry_t stim_table [NUM_ENTRIES] = '{
        '{1, 0, 2, 1, 3, 1, 0}, '{1, 0, 0, 1, 4, 1, 0}, '{1, 0, 1, 2, 1, 1, 0},
        '{1, 0, 1, 0, 2, 1, 0}, '{1, 0, 1, 1, 0, 1, 0},
        '{2, 1, 1, 1, 0, 3, 0}, '{2, 2, 1, 1, 0, 3, 0}, '{2, 3, 1, 1, 0, 3, 0},
        '{2, 4, 1, 1, 0, 3, 0},
        '{3, 0, 2, 1, 3, 6, 1},
        '{4, 1, 3, 0, 3, 2, 0}, '{4, 2, 0, 3, 4, 2, 0}, '{4, 3, 1, 3, 1, 2, 0},
        '{4, 4, 1, 1, 0, 2, 0}, '{4, 0, 1, 0, 2, 2, 0},
        '{5, 1, 1, 1, 0, 6, 1}, '{5, 2, 1, 2, 1, 1, 0}
    };

    string test_names [NUM_TESTS] = '{"routing", "contention", "back-pressure",
                                      "upstream credits", "reset"};

    logic               clk;
    logic               reset;
    noc_pkg::flit_t     in_flit [NUM_PORTS];
    noc_pkg::port_vec_t in_valid;
    noc_pkg::port_vec_t credit_in;
    noc_pkg::flit_t     out_flit [NUM_PORTS];
    noc_pkg::port_vec_t out_valid;
    noc_pkg::port_vec_t credit_out;

    pend_t pend_q [NUM_PORTS][$];
    sb_t   sb_q [NUM_PORTS][NUM_PORTS][$];

    int    up_credits [NUM_PORTS];
    int    owed [NUM_PORTS];
    bit    hold [NUM_PORTS];
    int    delivered [NUM_PORTS];
    int    sent [NUM_PORTS];
    int    pulses [NUM_PORTS];
    int    cycle_count;
    int    cycle_limit;
    int    errors;
    int    test_errors;
    int    tests_failed;
    bit    check_latency;
    logic [31:0] rng_state;

    router_top #(
        .BUFFER_DEPTH (BUFFER_DEPTH),
        .ROUTER_X     (1),
        .ROUTER_Y     (1)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .in_flit    (in_flit),
        .in_valid   (in_valid),
        .credit_in  (credit_in),
        .out_flit   (out_flit),
        .out_valid  (out_valid),
        .credit_out (credit_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog on the cycle count
    initial begin
        @(posedge clk);
        wait (cycle_count > cycle_limit);
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // XY rule at router (1,1), X first
    function automatic int xy_port(input int dx, input int dy);
        if (dx > 1) return noc_pkg::PORT_EAST;
        if (dx < 1) return noc_pkg::PORT_WEST;
        if (dy > 1) return noc_pkg::PORT_NORTH;
        if (dy < 1) return noc_pkg::PORT_SOUTH;
        return noc_pkg::PORT_LOCAL;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("Fail %s expected %h actual %h", name, exp_val, act_val);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic observe_outputs();
        sb_t exp_e;
        int  src;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o]) begin
                src = int'(out_flit[o].payload[27:25]);
                if (src >= NUM_PORTS || sb_q[o][src].size() == 0) begin
                    report_error($sformatf("Unexpected flit %h arrived on output %0d",
                                           out_flit[o], o));
                end else begin
                    exp_e = sb_q[o][src].pop_front();
                    compare("out_flit", exp_e.flit, out_flit[o]);
                    if (check_latency)
                        compare("latency", exp_e.send_cycle + 2, cycle_count);
                end
                delivered[o]++;
                owed[o]++;
            end
            if (!hold[o] && owed[o] > 0) begin
                credit_in[o] = 1'b1;
                owed[o]--;
            end
            if (credit_out[o]) begin
                pulses[o]++;
                up_credits[o]++;
            end
        end
    endtask

    // One clock cycle: sample outputs, return credits, send what credits allow
    task automatic next_cycle();
        pend_t p;
        sb_t   e;
        @(negedge clk);
        cycle_count++;
        in_valid  = '0;
        credit_in = '0;
        observe_outputs();
        for (int s = 0; s < NUM_PORTS; s++) begin
            if (pend_q[s].size() > 0 && up_credits[s] > 0) begin
                p = pend_q[s].pop_front();
                in_flit[s]  = p.flit;
                in_valid[s] = 1'b1;
                up_credits[s]--;
                sent[s]++;
                e.flit       = p.flit;
                e.send_cycle = cycle_count;
                sb_q[p.port][s].push_back(e);
            end
        end
    endtask

    function automatic bit network_idle();
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pend_q[i].size() > 0 || owed[i] > 0)
                return 1'b0;
            for (int j = 0; j < NUM_PORTS; j++)
                if (sb_q[i][j].size() > 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_idle();
        do next_cycle(); while (!network_idle());
    endtask

    // Wait until a held output has spent all its credits, then watch it stay quiet
    task automatic wait_blocked(input int port);
        while (pend_q[0].size() + pend_q[1].size() + pend_q[2].size() + pend_q[3].size() +
               pend_q[4].size() > 0 || delivered[port] < BUFFER_DEPTH)
            next_cycle();
        repeat (8) next_cycle();
        compare("blocked_output_count", BUFFER_DEPTH, delivered[port]);
    endtask

    task automatic apply_reset();
        reset     = 1'b1;
        in_valid  = '0;
        credit_in = '0;
        repeat (2) begin
            @(negedge clk);
            cycle_count++;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            pend_q[i].delete();
            for (int j = 0; j < NUM_PORTS; j++) sb_q[i][j].delete();
            up_credits[i] = BUFFER_DEPTH;
            owed[i]       = 0;
            hold[i]       = 1'b0;
            sent[i]       = 0;
            pulses[i]     = 0;
            delivered[i]  = 0;
        end
        reset    = 1'b0;
        next_cycle();
        compare("out_valid", '0, out_valid);
        compare("credit_out", '0, credit_out);
    endtask

    task automatic queue_entry(input entry_t e);
        pend_t p;
        compare("xy_route", xy_port(e.dx, e.dy), e.exp_port);
        for (int n = 0; n < e.count; n++) begin
            rng_state       = xorshift32(rng_state);
            p.flit.dst_x    = noc_pkg::coord_t'(e.dx);
            p.flit.dst_y    = noc_pkg::coord_t'(e.dy);
            p.flit.payload  = {3'(e.src), rng_state[24:0]};
            p.port          = e.exp_port;
            pend_q[e.src].push_back(p);
        end
    endtask

    initial begin
        int total;
        reset       = 1'b1;
        in_valid    = '0;
        credit_in   = '0;
        for (int i = 0; i < NUM_PORTS; i++) in_flit[i] = '0;
        rng_state   = 32'h076d_775d;
        errors      = 0;
        tests_failed = 0;
        cycle_count = 0;
        total       = 0;
        for (int k = 0; k < NUM_ENTRIES; k++) total += stim_table[k].count;
        cycle_limit = 20 * total + 200;
        check_latency = 1'b0;
        apply_reset();

        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_errors   = 0;
            check_latency = (t == 1);
            for (int i = 0; i < NUM_PORTS; i++) begin
                sent[i]      = 0;
                pulses[i]    = 0;
                delivered[i] = 0;
            end
            for (int k = 0; k < NUM_ENTRIES; k++) begin
                if (stim_table[k].test == t) begin
                    if (stim_table[k].hold) hold[stim_table[k].exp_port] = 1'b1;
                    queue_entry(stim_table[k]);
                    if (t == 1) wait_idle();
                    if (stim_table[k].hold) begin
                        wait_blocked(stim_table[k].exp_port);
                        // Flits left in the FIFO are dropped by reset in test 5
                        if (t == 5) apply_reset();
                        else hold[stim_table[k].exp_port] = 1'b0;
                    end
                end
            end
            wait_idle();
            for (int i = 0; i < NUM_PORTS; i++) begin
                compare("credit_out_pulses", sent[i], pulses[i]);
                compare("upstream_credits", BUFFER_DEPTH, up_credits[i]);
            end
            if (test_errors == 0) begin
                $display("Test %0d %s: ok", t, test_names[t-1]);
            end else begin
                $display("Test %0d %s: failed with %0d errors", t, test_names[t-1],
                         test_errors);
                tests_failed++;
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
noc_pkg.sv
flit_fifo.sv
input_port.sv
switch_allocator.sv
crossbar.sv
router_top.sv
router_asserts.sv
tb_router.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_router
FILELIST   = sim.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
